/* drone_rate_pkg.sv */
//******************************
// Rate controller package
// Fixed-point rate types, the per-axis sample and the cycle FSM states
//******************************

package drone_rate_pkg;

	// Widths of the fixed-point formats
	localparam int RATE_W = 16;
	localparam int OPS_W = 32;
	localparam int SHIFT_W = 5;

	// Fractional bits of the 12.4 rate format
	localparam int FRAC_BITS = 4;

	// Rate in deg/s, signed 12.4
	typedef logic signed [RATE_W-1:0] rate_t;

	// Working width for error, integrator, products and sums
	typedef logic signed [OPS_W-1:0] ops_t;

	// Gain shift amount
	typedef logic [SHIFT_W-1:0] shift_t;

	// One axis worth of captured inputs
	// actual is already sign corrected for the IMU mounting
	typedef struct packed {
		rate_t target;
		rate_t actual;
		rate_t angle_error;
	} axis_sample_t;

	// Unclamped PID sums of all three axes
	typedef struct packed {
		ops_t yaw;
		ops_t pitch;
		ops_t roll;
	} axis_sum_t;

	// Control cycle FSM
	typedef enum logic [1:0] {
		WAITING,
		ACTIVE,
		COMPLETE
	} ctrl_state_t;

endpackage

/* rate_sample_latch.sv */
//******************************
// Rate sample latch
// Detects an accepted start rise and captures one sample per axis
//******************************

`timescale 1ns/1ns

module rate_sample_latch (
	input logic us_clk,
	input logic resetn,
	input logic start_signal,
	input logic accept,
	input drone_rate_pkg::rate_t yaw_target,
	input drone_rate_pkg::rate_t pitch_target,
	input drone_rate_pkg::rate_t roll_target,
	input drone_rate_pkg::rate_t yaw_rotation,
	input drone_rate_pkg::rate_t pitch_rotation,
	input drone_rate_pkg::rate_t roll_rotation,
	input drone_rate_pkg::rate_t pitch_angle_error,
	input drone_rate_pkg::rate_t roll_angle_error,
	output drone_rate_pkg::axis_sample_t yaw_sample,
	output drone_rate_pkg::axis_sample_t pitch_sample,
	output drone_rate_pkg::axis_sample_t roll_sample,
	output logic sample_valid
);
	import drone_rate_pkg::*;

	logic start_prev;
	logic capture_q;
	logic take;

	// Rising start while idle and no sample is pending
	assign take = start_signal && !start_prev && accept && !sample_valid;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_prev <= 1'b0;
			capture_q <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			start_prev <= start_signal;
			capture_q <= take;
			// Valid follows the capture by one edge
			sample_valid <= capture_q;
		end
	end

	// Yaw and pitch IMU axes are mounted inverted
	always_ff @(posedge us_clk) begin
		if (take) begin
			yaw_sample.target <= yaw_target;
			yaw_sample.actual <= -yaw_rotation;
			yaw_sample.angle_error <= rate_t'(0);

			pitch_sample.target <= pitch_target;
			pitch_sample.actual <= -pitch_rotation;
			pitch_sample.angle_error <= pitch_angle_error;

			roll_sample.target <= roll_target;
			roll_sample.actual <= roll_rotation;
			roll_sample.angle_error <= roll_angle_error;
		end
	end

	// A new cycle may only start from the idle state
	a_valid_only_when_accepted: assert property (
		@(posedge us_clk) disable iff (!resetn)
		$rose(sample_valid) |-> accept
	) else $error("sample_valid rose while accept was low");

endmodule

/* pid_axis.sv */
//******************************
// PID axis
// Three-stage PID step for one axis with integrator state
//******************************

`timescale 1ns/1ns

module pid_axis #(
	parameter drone_rate_pkg::ops_t K_P = 5,
	parameter drone_rate_pkg::ops_t K_I = 3,
	parameter drone_rate_pkg::ops_t K_D = 4,
	parameter drone_rate_pkg::shift_t K_SHIFT = 4
) (
	input logic us_clk,
	input logic resetn,
	input logic sample_valid,
	input drone_rate_pkg::axis_sample_t sample,
	output logic busy,
	output logic done,
	output drone_rate_pkg::ops_t pid_sum
);
	import drone_rate_pkg::*;

	ops_t error;
	ops_t integ;
	ops_t integ_next;
	ops_t prev_error;
	ops_t p_prod;
	ops_t i_prod;
	ops_t d_prod;
	logic s1_valid;
	logic s2_valid;

	// Integrator including the current error
	assign integ_next = integ + error;

	// Pipeline control
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			done <= 1'b0;
			busy <= 1'b0;
		end else begin
			s1_valid <= sample_valid;
			s2_valid <= s1_valid;
			done <= s2_valid;
			if (sample_valid)
				busy <= 1'b1;
			else if (s2_valid)
				busy <= 1'b0;
		end
	end

	// Stage 1, error term
	always_ff @(posedge us_clk) begin
		if (sample_valid)
			error <= ops_t'(sample.target) - ops_t'(sample.actual)
				+ ops_t'(sample.angle_error);
	end

	// Stage 2, gain products
	always_ff @(posedge us_clk) begin
		if (s1_valid) begin
			p_prod <= error * K_P;
			i_prod <= integ_next * K_I;
			d_prod <= (error - prev_error) * K_D;
		end
	end

	// State carried from one control cycle to the next
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			integ <= '0;
			prev_error <= '0;
			pid_sum <= '0;
		end else begin
			if (s1_valid)
				integ <= integ_next;
			// Stage 3, scale and sum
			if (s2_valid) begin
				pid_sum <= (p_prod >>> K_SHIFT) + (i_prod >>> K_SHIFT)
					+ (d_prod >>> K_SHIFT);
				prev_error <= error;
			end
		end
	end

	// done closes a step that busy opened
	a_done_after_busy: assert property (
		@(posedge us_clk) disable iff (!resetn)
		done |-> $past(busy)
	) else $error("done without busy in the previous cycle");

endmodule

/* rate_result_stage.sv */
//******************************
// Rate result stage
// Saturates the PID sums and registers the mixer outputs
//******************************

`timescale 1ns/1ns

module rate_result_stage #(
	parameter drone_rate_pkg::ops_t RATE_LIMIT = 4000
) (
	input logic us_clk,
	input logic resetn,
	input logic sums_valid,
	input drone_rate_pkg::axis_sum_t sums,
	output drone_rate_pkg::rate_t yaw_rate_out,
	output drone_rate_pkg::rate_t pitch_rate_out,
	output drone_rate_pkg::rate_t roll_rate_out,
	output logic complete_signal
);
	import drone_rate_pkg::*;

	// Clamp to +/- RATE_LIMIT, then drop to the rate width
	function automatic rate_t saturate(input ops_t value);
		ops_t limited;
		if (value > RATE_LIMIT)
			limited = RATE_LIMIT;
		else if (value < -RATE_LIMIT)
			limited = -RATE_LIMIT;
		else
			limited = value;
		return rate_t'(limited);
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			yaw_rate_out <= '0;
			pitch_rate_out <= '0;
			roll_rate_out <= '0;
			complete_signal <= 1'b0;
		end else begin
			complete_signal <= sums_valid;
			// Outputs hold until the next cycle
			if (sums_valid) begin
				yaw_rate_out <= saturate(sums.yaw);
				pitch_rate_out <= saturate(sums.pitch);
				roll_rate_out <= saturate(sums.roll);
			end
		end
	end

	// One pulse per control cycle
	a_complete_single: assert property (
		@(posedge us_clk) disable iff (!resetn)
		complete_signal |=> !complete_signal
	) else $error("complete_signal high for two cycles");

endmodule

/* body_frame_controller.sv */
//******************************
// Body frame rate controller
// Cycle FSM with sample latch, three PID axes and result stage
//******************************

`timescale 1ns/1ns

module body_frame_controller #(
	parameter drone_rate_pkg::ops_t RATE_LIMIT = 250 << drone_rate_pkg::FRAC_BITS,
	parameter drone_rate_pkg::ops_t YAW_K_P = 48,
	parameter drone_rate_pkg::ops_t YAW_K_I = 0,
	parameter drone_rate_pkg::ops_t YAW_K_D = 5,
	parameter drone_rate_pkg::shift_t YAW_K_SHIFT = 4,
	parameter drone_rate_pkg::ops_t PITCH_K_P = 5,
	parameter drone_rate_pkg::ops_t PITCH_K_I = 3,
	parameter drone_rate_pkg::ops_t PITCH_K_D = 4,
	parameter drone_rate_pkg::shift_t PITCH_K_SHIFT = 4,
	parameter drone_rate_pkg::ops_t ROLL_K_P = 5,
	parameter drone_rate_pkg::ops_t ROLL_K_I = 3,
	parameter drone_rate_pkg::ops_t ROLL_K_D = 4,
	parameter drone_rate_pkg::shift_t ROLL_K_SHIFT = 4
) (
	input drone_rate_pkg::rate_t yaw_target,
	input drone_rate_pkg::rate_t roll_target,
	input drone_rate_pkg::rate_t pitch_target,
	input drone_rate_pkg::rate_t yaw_rotation,
	input drone_rate_pkg::rate_t roll_rotation,
	input drone_rate_pkg::rate_t pitch_rotation,
	input drone_rate_pkg::rate_t roll_angle_error,
	input drone_rate_pkg::rate_t pitch_angle_error,
	input logic start_signal,
	input logic resetn,
	input logic us_clk,
	output drone_rate_pkg::rate_t yaw_rate_out,
	output drone_rate_pkg::rate_t roll_rate_out,
	output drone_rate_pkg::rate_t pitch_rate_out,
	output logic complete_signal
);
	import drone_rate_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic accept;
	logic sample_valid;
	axis_sample_t yaw_sample;
	axis_sample_t pitch_sample;
	axis_sample_t roll_sample;
	logic yaw_busy, pitch_busy, roll_busy;
	logic yaw_done, pitch_done, roll_done;
	logic all_done;
	ops_t yaw_sum, pitch_sum, roll_sum;
	axis_sum_t sums;

	// New cycles are only taken while idle
	assign accept = (state == WAITING);
	// Axes run in lockstep so the dones coincide
	assign all_done = yaw_done && pitch_done && roll_done;

	assign sums.yaw = yaw_sum;
	assign sums.pitch = pitch_sum;
	assign sums.roll = roll_sum;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= WAITING;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			WAITING:  if (sample_valid) next_state = ACTIVE;
			ACTIVE:   if (all_done) next_state = COMPLETE;
			COMPLETE: next_state = WAITING;
			default:  next_state = WAITING;
		endcase
	end

	rate_sample_latch u_latch (
		.us_clk(us_clk),
		.resetn(resetn),
		.start_signal(start_signal),
		.accept(accept),
		.yaw_target(yaw_target),
		.pitch_target(pitch_target),
		.roll_target(roll_target),
		.yaw_rotation(yaw_rotation),
		.pitch_rotation(pitch_rotation),
		.roll_rotation(roll_rotation),
		.pitch_angle_error(pitch_angle_error),
		.roll_angle_error(roll_angle_error),
		.yaw_sample(yaw_sample),
		.pitch_sample(pitch_sample),
		.roll_sample(roll_sample),
		.sample_valid(sample_valid)
	);

	pid_axis #(
		.K_P(YAW_K_P), .K_I(YAW_K_I), .K_D(YAW_K_D), .K_SHIFT(YAW_K_SHIFT)
	) yaw_pid (
		.us_clk(us_clk),
		.resetn(resetn),
		.sample_valid(sample_valid),
		.sample(yaw_sample),
		.busy(yaw_busy),
		.done(yaw_done),
		.pid_sum(yaw_sum)
	);

	pid_axis #(
		.K_P(PITCH_K_P), .K_I(PITCH_K_I), .K_D(PITCH_K_D), .K_SHIFT(PITCH_K_SHIFT)
	) pitch_pid (
		.us_clk(us_clk),
		.resetn(resetn),
		.sample_valid(sample_valid),
		.sample(pitch_sample),
		.busy(pitch_busy),
		.done(pitch_done),
		.pid_sum(pitch_sum)
	);

	pid_axis #(
		.K_P(ROLL_K_P), .K_I(ROLL_K_I), .K_D(ROLL_K_D), .K_SHIFT(ROLL_K_SHIFT)
	) roll_pid (
		.us_clk(us_clk),
		.resetn(resetn),
		.sample_valid(sample_valid),
		.sample(roll_sample),
		.busy(roll_busy),
		.done(roll_done),
		.pid_sum(roll_sum)
	);

	rate_result_stage #(
		.RATE_LIMIT(RATE_LIMIT)
	) u_result (
		.us_clk(us_clk),
		.resetn(resetn),
		.sums_valid(all_done),
		.sums(sums),
		.yaw_rate_out(yaw_rate_out),
		.pitch_rate_out(pitch_rate_out),
		.roll_rate_out(roll_rate_out),
		.complete_signal(complete_signal)
	);

	// PID work only happens inside an active cycle
	a_busy_in_active: assert property (
		@(posedge us_clk) disable iff (!resetn)
		(yaw_busy || pitch_busy || roll_busy) |-> (state == ACTIVE)
	) else $error("PID axis busy outside the ACTIVE state");

endmodule

/* tb_pid_model.svh */
//******************************
// PID reference model
// Per-axis PID step with sign correction and clamp
//******************************

`ifndef TB_PID_MODEL_SVH
`define TB_PID_MODEL_SVH

// One control cycle for one axis, updates the integrator and previous error
function automatic drone_rate_pkg::rate_t model_pid_step(
	input drone_rate_pkg::rate_t target,
	input drone_rate_pkg::rate_t rotation,
	input drone_rate_pkg::rate_t angle_error,
	input bit negate,
	input drone_rate_pkg::ops_t k_p,
	input drone_rate_pkg::ops_t k_i,
	input drone_rate_pkg::ops_t k_d,
	input drone_rate_pkg::shift_t k_shift,
	input drone_rate_pkg::ops_t rate_limit,
	inout drone_rate_pkg::ops_t integ,
	inout drone_rate_pkg::ops_t prev_error
);
	drone_rate_pkg::rate_t actual;
	drone_rate_pkg::ops_t error;
	drone_rate_pkg::ops_t sum;
	actual = negate ? -rotation : rotation;
	error = drone_rate_pkg::ops_t'(target) - drone_rate_pkg::ops_t'(actual)
		+ drone_rate_pkg::ops_t'(angle_error);
	integ = integ + error;
	sum = ((error * k_p) >>> k_shift) + ((integ * k_i) >>> k_shift)
		+ (((error - prev_error) * k_d) >>> k_shift);
	prev_error = error;
	if (sum > rate_limit)
		sum = rate_limit;
	else if (sum < -rate_limit)
		sum = -rate_limit;
	return drone_rate_pkg::rate_t'(sum);
endfunction

`endif

/* tb_body_frame_controller.sv */
//******************************
// Body frame controller testbench
// Drives control cycles and checks the rates against a PID model
//******************************

`timescale 1ns/1ns

module tb_body_frame_controller;
	import drone_rate_pkg::*;

	`include "tb_pid_model.svh"

	localparam ops_t RATE_LIMIT = 4000;
	localparam ops_t YAW_K_P = 48;
	localparam ops_t YAW_K_I = 0;
	localparam ops_t YAW_K_D = 5;
	localparam shift_t YAW_K_SHIFT = 5'd4;
	localparam ops_t PR_K_P = 5;
	localparam ops_t PR_K_I = 3;
	localparam ops_t PR_K_D = 4;
	localparam shift_t PR_K_SHIFT = 5'd4;
	// About 60 cycles of about 10 clocks each with margin
	localparam int MAX_CYCLES = 1500;

	logic us_clk = 1'b0;
	logic resetn;
	logic start_signal;
	rate_t yaw_target, pitch_target, roll_target;
	rate_t yaw_rotation, pitch_rotation, roll_rotation;
	rate_t pitch_angle_error, roll_angle_error;
	rate_t yaw_rate_out, pitch_rate_out, roll_rate_out;
	logic complete_signal;

	int seed = 32'h6a4a;
	int cycle_count = 0;
	int complete_count = 0;
	int complete_cycle = 0;
	int cycles_run = 0;
	int value_errors = 0;
	int other_errors = 0;

	// Model state per axis
	ops_t yaw_integ = 0, pitch_integ = 0, roll_integ = 0;
	ops_t yaw_prev = 0, pitch_prev = 0, roll_prev = 0;

	// Latest model results
	rate_t model_yaw = 0, model_pitch = 0, model_roll = 0;

	// Expected results with one entry per started cycle
	rate_t exp_yaw[$], exp_pitch[$], exp_roll[$];
	string exp_name[$];

	always #50 us_clk = ~us_clk;

	body_frame_controller #(
		.RATE_LIMIT(RATE_LIMIT),
		.YAW_K_P(YAW_K_P), .YAW_K_I(YAW_K_I), .YAW_K_D(YAW_K_D), .YAW_K_SHIFT(YAW_K_SHIFT),
		.PITCH_K_P(PR_K_P), .PITCH_K_I(PR_K_I), .PITCH_K_D(PR_K_D), .PITCH_K_SHIFT(PR_K_SHIFT),
		.ROLL_K_P(PR_K_P), .ROLL_K_I(PR_K_I), .ROLL_K_D(PR_K_D), .ROLL_K_SHIFT(PR_K_SHIFT)
	) DUT (.*);

	task automatic check_rate(input string name, input string axis, input rate_t expected,
			input rate_t actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("FAIL %s %s: expected %0d, actual %0d", name, axis, expected, actual);
		end
	endtask

	function automatic rate_t random_rate();
		return rate_t'($random(seed) % 2048);
	endfunction

	// Cycle counter with the run limit
	always @(posedge us_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: no end of test after %0d cycles", cycle_count);
			$display("Errors: %0d value, %0d other", value_errors, other_errors);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Compare the outputs on the falling edge after complete_signal
	always @(negedge us_clk) begin
		if (resetn && complete_signal) begin
			complete_count++;
			complete_cycle = cycle_count;
			assert (exp_name.size() != 0) else begin
				other_errors++;
				$display("complete_signal pulsed with no cycle started, clock %0d", cycle_count);
			end
			if (exp_name.size() != 0) begin
				check_rate(exp_name[0], "yaw", exp_yaw.pop_front(), yaw_rate_out);
				check_rate(exp_name[0], "pitch", exp_pitch.pop_front(), pitch_rate_out);
				check_rate(exp_name[0], "roll", exp_roll.pop_front(), roll_rate_out);
				void'(exp_name.pop_front());
			end
		end
	end

	// One control cycle with an optional second start rise while it runs
	task automatic run_cycle(input string name, input rate_t yt, input rate_t pt, input rate_t rt,
			input rate_t yr, input rate_t pr, input rate_t rr, input rate_t pae, input rate_t rae,
			input bit extra_rise);
		int start_edge;
		int wanted;
		@(negedge us_clk);
		yaw_target = yt;
		pitch_target = pt;
		roll_target = rt;
		yaw_rotation = yr;
		pitch_rotation = pr;
		roll_rotation = rr;
		pitch_angle_error = pae;
		roll_angle_error = rae;
		start_signal = 1'b1;
		start_edge = cycle_count + 1;
		wanted = complete_count + 1;
		cycles_run++;
		// Yaw and pitch IMU values are negated and yaw takes no angle error
		exp_yaw.push_back(model_pid_step(yt, yr, rate_t'(0), 1'b1, YAW_K_P, YAW_K_I, YAW_K_D,
			YAW_K_SHIFT, RATE_LIMIT, yaw_integ, yaw_prev));
		exp_pitch.push_back(model_pid_step(pt, pr, pae, 1'b1, PR_K_P, PR_K_I, PR_K_D,
			PR_K_SHIFT, RATE_LIMIT, pitch_integ, pitch_prev));
		exp_roll.push_back(model_pid_step(rt, rr, rae, 1'b0, PR_K_P, PR_K_I, PR_K_D,
			PR_K_SHIFT, RATE_LIMIT, roll_integ, roll_prev));
		exp_name.push_back(name);
		model_yaw = exp_yaw[$];
		model_pitch = exp_pitch[$];
		model_roll = exp_roll[$];
		repeat (2) @(negedge us_clk);
		start_signal = 1'b0;
		if (extra_rise) begin
			@(negedge us_clk);
			start_signal = 1'b1;
			yaw_target = yt + 16'sd100;
			pitch_target = pt - 16'sd100;
			roll_rotation = rr + 16'sd50;
			@(negedge us_clk);
			start_signal = 1'b0;
		end
		wait (complete_count == wanted);
		assert (complete_cycle - start_edge == 5) else begin
			other_errors++;
			$display("%s: complete_signal came %0d edges after the start edge, not 5", name,
				complete_cycle - start_edge);
		end
		repeat (2) @(negedge us_clk);
	endtask

	initial begin
		rate_t prev_y, prev_p, prev_r;
		rate_t yaw_b;
		int count_before;
		resetn = 1'b0;
		start_signal = 1'b0;
		yaw_target = '0;
		pitch_target = '0;
		roll_target = '0;
		yaw_rotation = '0;
		pitch_rotation = '0;
		roll_rotation = '0;
		pitch_angle_error = '0;
		roll_angle_error = '0;
		repeat (5) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;

		// Quiet after reset until the first start
		repeat (6) begin
			@(negedge us_clk);
			check_rate("reset", "yaw", '0, yaw_rate_out);
			check_rate("reset", "pitch", '0, pitch_rate_out);
			check_rate("reset", "roll", '0, roll_rate_out);
			assert (!complete_signal) else begin
				other_errors++;
				$display("complete_signal high after reset before any start");
			end
		end

		run_cycle("single_small", 16'sd32, -16'sd16, 16'sd48, 16'sd8, -16'sd8, 16'sd16,
			16'sd4, -16'sd4, 1'b0);

		// Integral term builds up on pitch and roll under a constant angle error
		for (int k = 0; k < 6; k++) begin
			prev_y = model_yaw;
			prev_p = model_pitch;
			prev_r = model_roll;
			run_cycle("integral_build", 16'sd16, '0, '0, '0, '0, '0, 16'sd32, 16'sd32, 1'b0);
			if (k >= 2) begin
				check_rate("integral_build", "yaw hold", prev_y, yaw_rate_out);
				assert (pitch_rate_out > prev_p && roll_rate_out > prev_r) else begin
					value_errors++;
					$display("FAIL integral_build growth: expected above %0d/%0d, actual %0d/%0d",
						prev_p, prev_r, pitch_rate_out, roll_rate_out);
				end
			end
		end

		// Positive IMU yaw with zero target gives a positive yaw rate
		run_cycle("imu_sign", '0, '0, '0, 16'sd64, 16'sd64, 16'sd64, '0, '0, 1'b0);
		run_cycle("imu_sign", '0, '0, '0, 16'sd64, 16'sd64, 16'sd64, 16'sd800, 16'sd800, 1'b0);
		yaw_b = model_yaw;
		run_cycle("imu_sign", '0, '0, '0, 16'sd64, 16'sd64, 16'sd64, -16'sd800, -16'sd800, 1'b0);
		check_rate("yaw_angle_error", "yaw", yaw_b, yaw_rate_out);
		assert (yaw_rate_out > 0) else begin
			value_errors++;
			$display("FAIL imu_sign yaw: expected above 0, actual %0d", yaw_rate_out);
		end

		run_cycle("saturation", 16'sd28000, -16'sd28000, 16'sd28000, '0, '0, '0, '0, '0, 1'b0);
		check_rate("saturation", "yaw", 16'sd4000, yaw_rate_out);
		check_rate("saturation", "pitch", -16'sd4000, pitch_rate_out);
		check_rate("saturation", "roll", 16'sd4000, roll_rate_out);
		run_cycle("saturation", -16'sd28000, 16'sd28000, -16'sd28000, '0, '0, '0, '0, '0, 1'b0);
		check_rate("saturation", "yaw", -16'sd4000, yaw_rate_out);
		check_rate("saturation", "pitch", 16'sd4000, pitch_rate_out);
		check_rate("saturation", "roll", -16'sd4000, roll_rate_out);

		run_cycle("ignored_start", 16'sd40, 16'sd24, -16'sd24, 16'sd8, 16'sd8, -16'sd8,
			16'sd16, 16'sd16, 1'b1);
		count_before = complete_count;
		repeat (8) @(negedge us_clk);
		assert (complete_count == count_before) else begin
			other_errors++;
			$display("Start rise during a running cycle produced an extra complete_signal");
		end

		for (int n = 0; n < 40; n++)
			run_cycle("random", random_rate(), random_rate(), random_rate(), random_rate(),
				random_rate(), random_rate(), random_rate(), random_rate(), 1'b0);

		assert (exp_name.size() == 0 && complete_count == cycles_run) else begin
			other_errors++;
			$display("%0d cycles started but %0d completed", cycles_run, complete_count);
		end
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* sources.f */
+incdir+.
drone_rate_pkg.sv
rate_sample_latch.sv
pid_axis.sv
rate_result_stage.sv
body_frame_controller.sv
tb_body_frame_controller.sv

/* Makefile */
# Verilator build and run for the body frame rate controller

VERILATOR ?= verilator
TOP       ?= tb_body_frame_controller
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
